//--- vlog.f
logic/ooo_pkg.sv
logic/rename_table.sv
logic/ro_buffer.sv
logic/reservation_station.sv
logic/alu_unit.sv
logic/regfile.sv
logic/ooo_core.sv
tb/ooo_core_tb.sv

//--- Makefile
SIM       ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= vlog.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with $(SIM), run $(TOP), log to $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: SIM TOP FILELIST LOG OBJ_DIR SIM_FLAGS"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb;

    import ooo_pkg::*;

    localparam int cycles_per_instr = 40;
    localparam int cycle_margin     = 200;

    logic      clk = 1'b0;
    logic      reset;
    logic      flush;
    logic      issue;
    alu_op_t   op;
    rv32i_reg  rd;
    rv32i_reg  rs1;
    rv32i_reg  rs2;
    rv32i_word imm;
    logic      full;
    logic      commit;
    rv32i_reg  commit_rd;
    rv32i_word commit_value;

    // Reference model with program-order and committed register views
    rv32i_word spec_regs [32];
    rv32i_word arch_regs [32];
    rv32i_reg  exp_rd    [$];
    rv32i_word exp_value [$];

    string       test_name    = "reset";
    logic [31:0] lcg_state;
    int          n_dispatched = 0;
    int          n_committed  = 0;
    int          cycle_count  = 0;
    logic        full_seen    = 1'b0;

    ooo_core #(.rob_entries(8), .rs_entries(4)) dut (
        .clk(clk), .reset(reset), .flush(flush),
        .issue(issue), .op(op), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
        .full(full), .commit(commit),
        .commit_rd(commit_rd), .commit_value(commit_value)
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return (rand_next() >> 8) % n;
    endfunction

    // Expected result of one instruction
    function automatic rv32i_word expected_result(input alu_op_t o, input rv32i_word a,
                                                  input rv32i_word b, input rv32i_word i);
        rv32i_word r;
        case (o)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a + ~b + 32'd1;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            // Differing sign bits decide a signed compare
            OP_SLT:  r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            OP_ADDI: r = a + i;
            default: r = i;
        endcase
        return r;
    endfunction

    // Waits for room, drives one instruction and updates the model in program order
    task automatic dispatch_op(input alu_op_t o, input rv32i_reg d, input rv32i_reg s1,
                               input rv32i_reg s2, input rv32i_word i);
        rv32i_word result;
        while (full)
            @(negedge clk);
        result = expected_result(o, spec_regs[s1], spec_regs[s2], i);
        if (d != '0)
            spec_regs[d] = result;
        exp_rd.push_back(d);
        exp_value.push_back(result);
        n_dispatched++;
        op    = o;
        rd    = d;
        rs1   = s1;
        rs2   = s2;
        imm   = i;
        issue = 1'b1;
        @(negedge clk);
        issue = 1'b0;
    endtask

    // Registers drawn from base .. base+n_regs-1 to force dependencies
    task automatic dispatch_random(input int count, input int base, input int n_regs);
        alu_op_t  o;
        rv32i_reg d;
        rv32i_reg s1;
        rv32i_reg s2;
        for (int k = 0; k < count; k++) begin
            o  = alu_op_t'(rand_below(8));
            d  = rv32i_reg'(base + rand_below(n_regs));
            s1 = rv32i_reg'(base + rand_below(n_regs));
            s2 = rv32i_reg'(base + rand_below(n_regs));
            dispatch_op(o, d, s1, s2, rand_next());
        end
    endtask

    task automatic wait_drain();
        while (exp_rd.size() != 0)
            @(negedge clk);
    endtask

    // Everything not yet seen on the commit port is gone after the flush edge
    task automatic flush_pending();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        exp_rd.delete();
        exp_value.delete();
        for (int r = 0; r < 32; r++)
            spec_regs[r] = arch_regs[r];
        assert (!full && !commit)
            else fail_run("full or commit still high in the cycle after a flush");
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            cycle_count++;
            if (full)
                full_seen = 1'b1;
            if (cycle_count > cycles_per_instr * n_dispatched + cycle_margin)
                fail_run($sformatf("Timeout after %0d cycles in test %s, %0d commits missing",
                                   cycle_count, test_name, exp_rd.size()));
            if (commit) begin
                assert (exp_rd.size() != 0)
                    else fail_run($sformatf("Unexpected commit to x%0d in test %s",
                                            commit_rd, test_name));
                assert (commit_rd == exp_rd[0])
                    else fail_run($sformatf("[FAIL] %s: commit_rd expected %0d actual %0d",
                                            test_name, exp_rd[0], commit_rd));
                assert (commit_value == exp_value[0])
                    else fail_run($sformatf("[FAIL] %s: commit_value expected %08h actual %08h",
                                            test_name, exp_value[0], commit_value));
                if (commit_rd != '0)
                    arch_regs[commit_rd] = commit_value;
                void'(exp_rd.pop_front());
                void'(exp_value.pop_front());
                n_committed++;
            end
        end
    end

    initial begin
        lcg_state = 32'd68394;
        reset = 1'b1;
        flush = 1'b0;
        issue = 1'b0;
        op    = OP_ADD;
        rd    = '0;
        rs1   = '0;
        rs2   = '0;
        imm   = '0;
        for (int r = 0; r < 32; r++) begin
            spec_regs[r] = '0;
            arch_regs[r] = '0;
        end
        repeat (3) @(negedge clk);
        reset = 1'b0;

        test_name = "independent_chain";
        for (int r = 1; r <= 6; r++)
            dispatch_op(OP_LI, rv32i_reg'(r), 5'd0, 5'd0, rand_next());
        dispatch_op(OP_ADD, 5'd7, 5'd1, 5'd2, '0);
        dispatch_op(OP_SUB, 5'd8, 5'd3, 5'd4, '0);
        dispatch_op(OP_AND, 5'd9, 5'd5, 5'd6, '0);
        dispatch_op(OP_OR, 5'd10, 5'd1, 5'd6, '0);
        dispatch_op(OP_XOR, 5'd11, 5'd2, 5'd5, '0);
        dispatch_op(OP_SLT, 5'd12, 5'd3, 5'd1, '0);
        dispatch_op(OP_ADDI, 5'd13, 5'd4, 5'd0, 32'h0000_0100);
        wait_drain();

        test_name = "dependencies";
        for (int k = 0; k < 12; k++) begin
            dispatch_op(OP_ADDI, 5'd5, 5'd5, 5'd0, rv32i_word'(k + 1));
            dispatch_op(OP_ADD, 5'd6, 5'd5, 5'd6, '0);
            dispatch_random(1, 1, 4);
        end
        dispatch_random(30, 1, 4);
        wait_drain();

        test_name = "register_zero";
        dispatch_op(OP_LI, 5'd0, 5'd0, 5'd0, 32'h1234_5678);
        dispatch_op(OP_ADD, 5'd0, 5'd1, 5'd2, '0);
        dispatch_op(OP_ADD, 5'd3, 5'd0, 5'd0, '0);
        dispatch_op(OP_ADDI, 5'd4, 5'd0, 5'd0, 32'hffff_fff0);
        dispatch_op(OP_SUB, 5'd2, 5'd1, 5'd0, '0);
        dispatch_random(20, 0, 3);
        wait_drain();

        test_name = "full";
        full_seen = 1'b0;
        dispatch_random(60, 1, 3);
        wait_drain();
        assert (full_seen)
            else fail_run("full never rose during back-to-back dispatch");

        test_name = "flush";
        for (int f = 0; f < 6; f++) begin
            dispatch_random(1 + rand_below(10), 1, 4);
            flush_pending();
            // Any commit in these quiet cycles is caught by the checker
            repeat (4) @(negedge clk);
            dispatch_random(8, 0, 5);
            wait_drain();
        end

        $display("%0d instructions dispatched, %0d committed", n_dispatched, n_committed);
        $display("TB PASSED");
        $finish;
    end

endmodule : ooo_core_tb

//--- logic/ooo_core.sv
`timescale 1ns/1ps

module ooo_core #(
    parameter int rob_entries = 8,
    parameter int rs_entries  = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               issue,
    input  ooo_pkg::alu_op_t   op,
    input  ooo_pkg::rv32i_reg  rd,
    input  ooo_pkg::rv32i_reg  rs1,
    input  ooo_pkg::rv32i_reg  rs2,
    input  ooo_pkg::rv32i_word imm,
    output logic               full,
    output logic               commit,
    output ooo_pkg::rv32i_reg  commit_rd,
    output ooo_pkg::rv32i_word commit_value
);

    import ooo_pkg::*;

    localparam int tag_w = $clog2(rob_entries);

    logic             rs1_busy, rs2_busy;
    logic [tag_w-1:0] rs1_tag, rs2_tag;
    logic             look1_done, look2_done;
    rv32i_word        look1_value, look2_value;
    rv32i_word        rdata1, rdata2;
    logic [tag_w-1:0] alloc_tag;
    logic [tag_w-1:0] commit_tag;
    logic             rob_full, rs_full;

    logic             src1_ready, src2_ready;
    rv32i_word        src1_value, src2_value;

    logic             issue_valid;
    alu_op_t          issue_op;
    rv32i_word        issue_a, issue_b, issue_imm;
    logic [tag_w-1:0] issue_tag;

    logic             cdb_valid;
    logic [tag_w-1:0] cdb_tag;
    rv32i_word        cdb_value;

    assign full = rob_full | rs_full;

    // Operands at dispatch come from the regfile, a finished ROB entry or the bus
    assign src1_ready = (op == OP_LI) || !rs1_busy || look1_done
                        || (cdb_valid && cdb_tag == rs1_tag);
    assign src2_ready = (op == OP_LI) || (op == OP_ADDI) || !rs2_busy || look2_done
                        || (cdb_valid && cdb_tag == rs2_tag);
    assign src1_value = !rs1_busy ? rdata1 : (look1_done ? look1_value : cdb_value);
    assign src2_value = !rs2_busy ? rdata2 : (look2_done ? look2_value : cdb_value);

    rename_table #(.rob_entries(rob_entries)) u_rename (
        .clk(clk), .reset(reset), .flush(flush),
        .alloc(issue && rd != '0), .alloc_rd(rd), .alloc_tag(alloc_tag),
        .commit(commit), .commit_rd(commit_rd), .commit_tag(commit_tag),
        .rs1(rs1), .rs2(rs2),
        .rs1_busy(rs1_busy), .rs1_tag(rs1_tag),
        .rs2_busy(rs2_busy), .rs2_tag(rs2_tag)
    );

    reservation_station #(.rob_entries(rob_entries), .rs_entries(rs_entries)) u_rs (
        .clk(clk), .reset(reset), .flush(flush),
        .alloc(issue), .op(op), .imm(imm), .rob_tag(alloc_tag),
        .src1_ready(src1_ready), .src1_value(src1_value), .src1_tag(rs1_tag),
        .src2_ready(src2_ready), .src2_value(src2_value), .src2_tag(rs2_tag),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .full(rs_full), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b), .issue_imm(issue_imm),
        .issue_tag(issue_tag)
    );

    alu_unit #(.rob_entries(rob_entries)) u_alu (
        .clk(clk), .reset(reset), .flush(flush),
        .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b), .issue_imm(issue_imm),
        .issue_tag(issue_tag),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
    );

    ro_buffer #(.rob_entries(rob_entries)) u_rob (
        .clk(clk), .reset(reset), .flush(flush),
        .alloc(issue), .alloc_rd(rd),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .look1_tag(rs1_tag), .look2_tag(rs2_tag),
        .alloc_tag(alloc_tag), .full(rob_full),
        .look1_done(look1_done), .look1_value(look1_value),
        .look2_done(look2_done), .look2_value(look2_value),
        .commit(commit), .commit_rd(commit_rd),
        .commit_value(commit_value), .commit_tag(commit_tag)
    );

    regfile u_regfile (
        .clk(clk), .reset(reset),
        .we(commit), .waddr(commit_rd), .wdata(commit_value),
        .raddr1(rs1), .raddr2(rs2),
        .rdata1(rdata1), .rdata2(rdata2)
    );

endmodule : ooo_core

//--- logic/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic               clk,
    input  logic               reset,
    input  logic               we,
    input  ooo_pkg::rv32i_reg  waddr,
    input  ooo_pkg::rv32i_word wdata,
    input  ooo_pkg::rv32i_reg  raddr1,
    input  ooo_pkg::rv32i_reg  raddr2,
    output ooo_pkg::rv32i_word rdata1,
    output ooo_pkg::rv32i_word rdata2
);

    import ooo_pkg::*;

    // x0 has no storage
    rv32i_word regs [31:1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule : regfile

//--- logic/alu_unit.sv
`timescale 1ns/1ps

module alu_unit #(
    parameter int rob_entries = 8
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           flush,
    input  logic                           issue_valid,
    input  ooo_pkg::alu_op_t               issue_op,
    input  ooo_pkg::rv32i_word             issue_a,
    input  ooo_pkg::rv32i_word             issue_b,
    input  ooo_pkg::rv32i_word             issue_imm,
    input  logic [$clog2(rob_entries)-1:0] issue_tag,
    output logic                           cdb_valid,
    output logic [$clog2(rob_entries)-1:0] cdb_tag,
    output ooo_pkg::rv32i_word             cdb_value
);

    import ooo_pkg::*;

    // One-cycle pulse per issued op that a flush drops
    always_ff @(posedge clk) begin
        if (reset || flush)
            cdb_valid <= 1'b0;
        else
            cdb_valid <= issue_valid;
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            cdb_tag   <= issue_tag;
            cdb_value <= alu_eval(issue_op, issue_a, issue_b, issue_imm);
        end
    end

endmodule : alu_unit

//--- logic/reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
    parameter int rob_entries = 8,
    parameter int rs_entries  = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           flush,
    input  logic                           alloc,
    input  ooo_pkg::alu_op_t               op,
    input  ooo_pkg::rv32i_word             imm,
    input  logic [$clog2(rob_entries)-1:0] rob_tag,
    input  logic                           src1_ready,
    input  ooo_pkg::rv32i_word             src1_value,
    input  logic [$clog2(rob_entries)-1:0] src1_tag,
    input  logic                           src2_ready,
    input  ooo_pkg::rv32i_word             src2_value,
    input  logic [$clog2(rob_entries)-1:0] src2_tag,
    input  logic                           cdb_valid,
    input  logic [$clog2(rob_entries)-1:0] cdb_tag,
    input  ooo_pkg::rv32i_word             cdb_value,
    output logic                           full,
    output logic                           issue_valid,
    output ooo_pkg::alu_op_t               issue_op,
    output ooo_pkg::rv32i_word             issue_a,
    output ooo_pkg::rv32i_word             issue_b,
    output ooo_pkg::rv32i_word             issue_imm,
    output logic [$clog2(rob_entries)-1:0] issue_tag
);

    import ooo_pkg::*;

    localparam int tag_w = $clog2(rob_entries);
    localparam int idx_w = $clog2(rs_entries);

    logic [rs_entries-1:0] valid_q;
    logic [rs_entries-1:0] rdy1_q;
    logic [rs_entries-1:0] rdy2_q;
    alu_op_t               op_q   [rs_entries];
    rv32i_word             imm_q  [rs_entries];
    rv32i_word             val1_q [rs_entries];
    rv32i_word             val2_q [rs_entries];
    logic [tag_w-1:0]      tag_q  [rs_entries];
    logic [tag_w-1:0]      tag1_q [rs_entries];
    logic [tag_w-1:0]      tag2_q [rs_entries];

    logic [idx_w-1:0] free_idx;
    logic [idx_w-1:0] issue_idx;

    // Top-down scan leaves the lowest free and the lowest ready slot
    always_comb begin
        free_idx    = '0;
        issue_idx   = '0;
        issue_valid = 1'b0;
        for (int i = rs_entries - 1; i >= 0; i--) begin
            if (!valid_q[i])
                free_idx = idx_w'(i);
            if (valid_q[i] && rdy1_q[i] && rdy2_q[i]) begin
                issue_idx   = idx_w'(i);
                issue_valid = 1'b1;
            end
        end
    end

    assign full      = &valid_q;
    assign issue_op  = op_q[issue_idx];
    assign issue_a   = val1_q[issue_idx];
    assign issue_b   = val2_q[issue_idx];
    assign issue_imm = imm_q[issue_idx];
    assign issue_tag = tag_q[issue_idx];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_q <= '0;
        end else begin
            if (issue_valid)
                valid_q[issue_idx] <= 1'b0;
            if (alloc)
                valid_q[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        // Snoop the bus for waiting operands
        for (int i = 0; i < rs_entries; i++) begin
            if (valid_q[i] && cdb_valid && !rdy1_q[i] && tag1_q[i] == cdb_tag) begin
                rdy1_q[i] <= 1'b1;
                val1_q[i] <= cdb_value;
            end
            if (valid_q[i] && cdb_valid && !rdy2_q[i] && tag2_q[i] == cdb_tag) begin
                rdy2_q[i] <= 1'b1;
                val2_q[i] <= cdb_value;
            end
        end
        if (alloc) begin
            op_q[free_idx]   <= op;
            imm_q[free_idx]  <= imm;
            tag_q[free_idx]  <= rob_tag;
            rdy1_q[free_idx] <= src1_ready;
            val1_q[free_idx] <= src1_value;
            tag1_q[free_idx] <= src1_tag;
            rdy2_q[free_idx] <= src2_ready;
            val2_q[free_idx] <= src2_value;
            tag2_q[free_idx] <= src2_tag;
        end
    end

    // Issued op is complete, and its own result is not already on the bus
    a_issue_ready: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> rdy1_q[issue_idx] && rdy2_q[issue_idx]
                        && !(cdb_valid && cdb_tag == issue_tag))
        else $error("reservation_station: bad issue of tag %0d", issue_tag);

    // A full station would overwrite slot 0
    a_no_alloc_full: assert property (@(posedge clk) disable iff (reset)
        alloc |-> !full)
        else $error("reservation_station: dispatch while full");

endmodule : reservation_station

//--- logic/ro_buffer.sv
`timescale 1ns/1ps

module ro_buffer #(
    parameter int rob_entries = 8
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           flush,
    input  logic                           alloc,
    input  ooo_pkg::rv32i_reg              alloc_rd,
    input  logic                           cdb_valid,
    input  logic [$clog2(rob_entries)-1:0] cdb_tag,
    input  ooo_pkg::rv32i_word             cdb_value,
    input  logic [$clog2(rob_entries)-1:0] look1_tag,
    input  logic [$clog2(rob_entries)-1:0] look2_tag,
    output logic [$clog2(rob_entries)-1:0] alloc_tag,
    output logic                           full,
    output logic                           look1_done,
    output ooo_pkg::rv32i_word             look1_value,
    output logic                           look2_done,
    output ooo_pkg::rv32i_word             look2_value,
    output logic                           commit,
    output ooo_pkg::rv32i_reg              commit_rd,
    output ooo_pkg::rv32i_word             commit_value,
    output logic [$clog2(rob_entries)-1:0] commit_tag
);

    import ooo_pkg::*;

    localparam int tag_w = $clog2(rob_entries);

    rv32i_reg              rd_q    [rob_entries];
    rv32i_word             value_q [rob_entries];
    logic [rob_entries-1:0] done_q;

    logic [tag_w-1:0] head;
    logic [tag_w-1:0] tail;
    logic [tag_w:0]   count;
    logic             head_commit;
    logic [tag_w-1:0] cdb_off;

    assign alloc_tag   = tail;
    assign full        = (count == rob_entries);
    assign head_commit = (count != '0) && done_q[head];

    // Operand lookups at dispatch
    assign look1_done  = done_q[look1_tag];
    assign look1_value = value_q[look1_tag];
    assign look2_done  = done_q[look2_tag];
    assign look2_value = value_q[look2_tag];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
            commit <= 1'b0;
        end else begin
            commit <= head_commit;
            if (alloc) begin
                tail         <= tail + 1'b1;
                done_q[tail] <= 1'b0;
            end
            if (cdb_valid)
                done_q[cdb_tag] <= 1'b1;
            if (head_commit)
                head <= head + 1'b1;
            // Alloc and commit in one cycle leave the count unchanged
            if (alloc && !head_commit)
                count <= count + 1'b1;
            else if (!alloc && head_commit)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc)
            rd_q[tail] <= alloc_rd;
        if (cdb_valid)
            value_q[cdb_tag] <= cdb_value;
        if (head_commit) begin
            commit_rd    <= rd_q[head];
            commit_value <= value_q[head];
            commit_tag   <= head;
        end
    end

    // Bus tag distance from the head must fall inside the live window
    assign cdb_off = cdb_tag - head;

    a_no_alloc_full: assert property (@(posedge clk) disable iff (reset)
        alloc |-> !full)
        else $error("ro_buffer: dispatch while full");

    a_cdb_live: assert property (@(posedge clk) disable iff (reset)
        cdb_valid |-> (tag_w + 1)'(cdb_off) < count && !done_q[cdb_tag])
        else $error("ro_buffer: bus tag %0d not pending", cdb_tag);

endmodule : ro_buffer

//--- logic/rename_table.sv
`timescale 1ns/1ps

module rename_table #(
    parameter int rob_entries = 8
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           flush,
    input  logic                           alloc,
    input  ooo_pkg::rv32i_reg              alloc_rd,
    input  logic [$clog2(rob_entries)-1:0] alloc_tag,
    input  logic                           commit,
    input  ooo_pkg::rv32i_reg              commit_rd,
    input  logic [$clog2(rob_entries)-1:0] commit_tag,
    input  ooo_pkg::rv32i_reg              rs1,
    input  ooo_pkg::rv32i_reg              rs2,
    output logic                           rs1_busy,
    output logic [$clog2(rob_entries)-1:0] rs1_tag,
    output logic                           rs2_busy,
    output logic [$clog2(rob_entries)-1:0] rs2_tag
);

    localparam int tag_w = $clog2(rob_entries);

    logic [31:0]      busy_q;
    logic [tag_w-1:0] tag_q [32];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy_q <= '0;
        end else begin
            // Only the newest writer may release the register
            if (commit && tag_q[commit_rd] == commit_tag)
                busy_q[commit_rd] <= 1'b0;
            // A new allocation comes later and keeps the register busy
            if (alloc)
                busy_q[alloc_rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc)
            tag_q[alloc_rd] <= alloc_tag;
    end

    assign rs1_busy = busy_q[rs1];
    assign rs1_tag  = tag_q[rs1];
    assign rs2_busy = busy_q[rs2];
    assign rs2_tag  = tag_q[rs2];

    // x0 must never get a producer, otherwise its reads would wait on the ROB
    a_no_alloc_x0: assert property (@(posedge clk) disable iff (reset)
        alloc |-> alloc_rd != '0)
        else $error("rename_table: allocation targets x0");

endmodule : rename_table

//--- logic/ooo_pkg.sv
package ooo_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;
    typedef logic [2:0]  alu_op_t;

    // Register-register operations
    localparam alu_op_t OP_ADD  = 3'd0;
    localparam alu_op_t OP_SUB  = 3'd1;
    localparam alu_op_t OP_AND  = 3'd2;
    localparam alu_op_t OP_OR   = 3'd3;
    localparam alu_op_t OP_XOR  = 3'd4;
    localparam alu_op_t OP_SLT  = 3'd5;
    // Immediate forms ignore rs2 and OP_LI also ignores rs1
    localparam alu_op_t OP_ADDI = 3'd6;
    localparam alu_op_t OP_LI   = 3'd7;

    // Result rule of the ALU
    function automatic rv32i_word alu_eval(
        input alu_op_t   op,
        input rv32i_word a,
        input rv32i_word b,
        input rv32i_word imm
    );
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return {31'b0, $signed(a) < $signed(b)};
            OP_ADDI: return a + imm;
            OP_LI:   return imm;
            default: return '0;
        endcase
    endfunction

endpackage : ooo_pkg
